// ==== btac_golden.txt ====
# name clear stall get_pc0 get_pc1 | slot 0: pc npc addr jump branch jal | slot 1: same
# check | expected: branch baddr miss maddr cause hazard (all values hex)
cold      0 0 110 124   0 0 0 0 0 0   0 0 0 0 0 0   1 0 0 0 0 0 0
cold      0 0 0 0       0 0 0 0 0 0   0 0 0 0 0 0   1 0 0 0 0 0 0
unpred    0 0 0 0       110 114 400 1 1 0   0 0 0 0 0 0   1 0 0 0 0 0 1
unpred    0 0 110 0     0 0 0 0 0 0   0 0 0 0 0 0   1 0 0 1 400 3 0
hit       0 0 0 0       0 0 0 0 0 0   0 0 0 0 0 0   1 1 400 0 0 0 0
correct   0 0 0 0       110 114 400 1 1 0   0 0 0 0 0 0   1 0 0 0 0 0 0
correct   0 0 0 0       0 0 0 0 0 0   0 0 0 0 0 0   1 0 0 0 0 0 0
wrong_tgt 0 0 110 0     0 0 0 0 0 0   0 0 0 0 0 0   1 0 0 0 0 0 0
wrong_tgt 0 0 0 0       0 0 0 0 0 0   0 0 0 0 0 0   1 1 400 0 0 0 0
wrong_tgt 0 0 0 0       110 114 480 1 1 0   0 0 0 0 0 0   1 0 0 0 0 0 1
wrong_tgt 0 0 0 0       0 0 0 0 0 0   0 0 0 0 0 0   1 0 0 1 480 1 0
not_taken 0 0 110 0     0 0 0 0 0 0   0 0 0 0 0 0   1 0 0 0 0 0 0
not_taken 0 0 0 0       0 0 0 0 0 0   0 0 0 0 0 0   1 1 480 0 0 0 0
not_taken 0 0 0 0       110 114 0 0 1 0   0 0 0 0 0 0   1 0 0 0 0 0 1
not_taken 0 0 0 0       0 0 0 0 0 0   0 0 0 0 0 0   1 0 0 1 114 2 0
dual_hit  0 0 0 0       0 0 0 0 0 0   124 128 600 1 0 1   1 0 0 0 0 0 0
dual_hit  0 0 110 124   0 0 0 0 0 0   0 0 0 0 0 0   1 0 0 1 600 3 0
dual_hit  0 0 0 124     0 0 0 0 0 0   0 0 0 0 0 0   1 1 480 0 0 0 0
dual_hit  0 0 0 0       0 0 0 0 0 0   0 0 0 0 0 0   1 1 600 0 0 0 0
oldest    0 0 0 0       110 114 480 1 1 0   0 0 0 0 0 0   1 0 0 0 0 0 0
oldest    0 0 0 0       124 128 600 1 0 1   0 0 0 0 0 0   1 0 0 0 0 0 0
oldest    0 0 0 0       0 0 0 0 0 0   0 0 0 0 0 0   1 0 0 0 0 0 0
stall     0 0 110 0     0 0 0 0 0 0   0 0 0 0 0 0   1 0 0 0 0 0 0
stall     0 0 110 0     0 0 0 0 0 0   0 0 0 0 0 0   1 1 480 0 0 0 0
stall     0 1 0 0       0 0 0 0 0 0   0 0 0 0 0 0   1 0 0 0 0 0 0
stall     0 1 0 0       0 0 0 0 0 0   0 0 0 0 0 0   0 0 0 0 0 0 0
stall     0 1 0 0       0 0 0 0 0 0   0 0 0 0 0 0   0 0 0 0 0 0 0
stall     0 1 0 0       0 0 0 0 0 0   0 0 0 0 0 0   1 0 0 0 0 0 0
stall     0 0 0 0       110 114 4c0 1 1 0   0 0 0 0 0 0   1 0 0 0 0 0 1
stall     0 0 0 0       0 0 0 0 0 0   0 0 0 0 0 0   1 0 0 1 4c0 1 0
clear     0 0 110 0     0 0 0 0 0 0   0 0 0 0 0 0   1 0 0 0 0 0 0
clear     0 0 0 0       0 0 0 0 0 0   0 0 0 0 0 0   1 1 4c0 0 0 0 0
clear     1 0 0 0       140 144 800 1 1 0   0 0 0 0 0 0   1 0 0 0 0 0 0
clear     0 0 0 0       110 114 4c0 1 1 0   0 0 0 0 0 0   1 0 0 0 0 0 1
clear     0 0 140 0     0 0 0 0 0 0   0 0 0 0 0 0   1 0 0 1 4c0 3 0
clear     0 0 0 0       0 0 0 0 0 0   0 0 0 0 0 0   1 0 0 0 0 0 0
alias     0 0 0 0       1110 1114 900 1 0 1   0 0 0 0 0 0   1 0 0 0 0 0 1
alias     0 0 110 1110  0 0 0 0 0 0   0 0 0 0 0 0   1 0 0 1 900 3 0
alias     0 0 110 0     0 0 0 0 0 0   0 0 0 0 0 0   1 1 900 0 0 0 0
alias     0 0 0 0       0 0 0 0 0 0   0 0 0 0 0 0   1 0 0 0 0 0 0
alias     0 0 0 0       0 0 0 0 0 0   0 0 0 0 0 0   1 0 0 0 0 0 0

// ==== btac_pkg.sv ====
package btac_pkg;

  // Program counter and target address width
  localparam int addr_width = 32;

  // A BTB entry holds {target, branch pc, next pc}
  localparam int entry_width = 3 * addr_width;

  localparam int entry_taddr_lsb = 2 * addr_width;
  localparam int entry_pc_lsb = addr_width;
  localparam int entry_npc_lsb = 0;

  typedef enum logic [1:0] {
    miss_none,
    miss_target,
    miss_not_taken,
    miss_unpredicted
  } btac_miss_e;

endpackage

// ==== btac_predict.sv ====
`timescale 1ns/100ps

module btac_predict
  import btac_pkg::*;
#(
  parameter int btb_depth = 64
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           clear,
  input  logic                           stall,
  input  logic [addr_width-1:0]          get_pc0,
  input  logic [addr_width-1:0]          get_pc1,
  input  logic [entry_width-1:0]         rdata0,
  input  logic [entry_width-1:0]         rdata1,
  output logic [$clog2(btb_depth)-1:0]   raddr0,
  output logic [$clog2(btb_depth)-1:0]   raddr1,
  output logic                           pred_branch,
  output logic [addr_width-1:0]          pred_baddr,
  output logic [addr_width-1:0]          pred_pc,
  output logic [addr_width-1:0]          pred_npc
);

  localparam int idx_width = $clog2(btb_depth);

  logic [addr_width-1:0]  pc0_q;
  logic [addr_width-1:0]  pc1_q;
  logic                   hit0;
  logic                   hit1;
  logic [entry_width-1:0] entry;

  always_ff @(posedge clock) begin
    if (!reset) begin
      pc0_q <= '0;
      pc1_q <= '0;
    end else if (!clear) begin
      pc0_q <= get_pc0;
      pc1_q <= get_pc1;
    end
  end

  // On a flush keep indexing the held PCs so data and tags stay paired
  assign raddr0 = clear ? pc0_q[idx_width+1:2] : get_pc0[idx_width+1:2];
  assign raddr1 = clear ? pc1_q[idx_width+1:2] : get_pc1[idx_width+1:2];

  // Full PC compare where an empty entry never matches
  assign hit0 = (|rdata0) && (rdata0[entry_pc_lsb +: addr_width] == pc0_q);
  assign hit1 = (|rdata1) && (rdata1[entry_pc_lsb +: addr_width] == pc1_q);

  // Slot 0 wins when both hit
  assign entry = hit0 ? rdata0 : rdata1;

  always_comb begin
    if (stall || clear) begin
      pred_branch = 1'b0;
      pred_baddr = '0;
      pred_pc = '0;
      pred_npc = '0;
    end else begin
      pred_branch = hit0 || hit1;
      pred_baddr = (hit0 || hit1) ? entry[entry_taddr_lsb +: addr_width] : '0;
      pred_pc = (hit0 || hit1) ? entry[entry_pc_lsb +: addr_width] : '0;
      pred_npc = (hit0 || hit1) ? entry[entry_npc_lsb +: addr_width] : '0;
    end
  end

endmodule

// ==== btac_resolve.sv ====
`timescale 1ns/100ps

module btac_resolve
  import btac_pkg::*;
#(
  parameter int btb_depth = 64
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           clear,
  input  logic [addr_width-1:0]          upd_pc0,
  input  logic [addr_width-1:0]          upd_npc0,
  input  logic [addr_width-1:0]          upd_addr0,
  input  logic                           upd_jump0,
  input  logic                           upd_branch0,
  input  logic                           upd_jal0,
  input  logic [addr_width-1:0]          upd_pc1,
  input  logic [addr_width-1:0]          upd_npc1,
  input  logic [addr_width-1:0]          upd_addr1,
  input  logic                           upd_jump1,
  input  logic                           upd_branch1,
  input  logic                           upd_jal1,
  input  logic                           trk_taken,
  input  logic [addr_width-1:0]          trk_taddr,
  input  logic [addr_width-1:0]          trk_tpc,
  input  logic [addr_width-1:0]          trk_tnpc,
  output logic                           wen,
  output logic [$clog2(btb_depth)-1:0]   waddr,
  output logic [entry_width-1:0]         wdata,
  output logic                           trk_retire,
  output logic                           pred_miss,
  output logic [addr_width-1:0]          pred_maddr,
  output btac_miss_e                     pred_cause,
  output logic                           pred_hazard
);

  localparam int idx_width = $clog2(btb_depth);

  logic                  write0;
  logic                  write1;
  logic                  match0;
  logic                  match1;
  logic                  miss0;
  logic                  miss1;
  logic [addr_width-1:0] maddr;
  btac_miss_e            cause;

  // Only taken branches and jal go into the BTB
  assign write0 = upd_jump0 && (upd_branch0 || upd_jal0);
  assign write1 = upd_jump1 && (upd_branch1 || upd_jal1);

  assign wen = !clear && (write0 || write1);
  assign waddr = write0 ? upd_pc0[idx_width+1:2] : upd_pc1[idx_width+1:2];
  assign wdata = write0 ? {upd_addr0, upd_pc0, upd_npc0} : {upd_addr1, upd_pc1, upd_npc1};

  assign match0 = trk_taken && (upd_pc0 == trk_tpc);
  assign match1 = trk_taken && (upd_pc1 == trk_tpc);

  always_comb begin
    miss0 = 1'b0;
    miss1 = 1'b0;
    maddr = '0;
    cause = miss_none;
    trk_retire = 1'b0;
    if (!clear) begin
      if (match0) begin
        if (upd_jump0) begin
          trk_retire = 1'b1;
          if (upd_addr0 != trk_taddr) begin
            miss0 = 1'b1;
            maddr = upd_addr0;
            cause = miss_target;
          end
        end else if (upd_branch0) begin
          trk_retire = 1'b1;
          miss0 = 1'b1;
          maddr = trk_tnpc;
          cause = miss_not_taken;
        end
      end else if (match1) begin
        if (upd_jump1) begin
          trk_retire = 1'b1;
          if (upd_addr1 != trk_taddr) begin
            miss1 = 1'b1;
            maddr = upd_addr1;
            cause = miss_target;
          end
        end else if (upd_branch1) begin
          trk_retire = 1'b1;
          miss1 = 1'b1;
          maddr = trk_tnpc;
          cause = miss_not_taken;
        end
      end else if (upd_jump0) begin
        miss0 = 1'b1;
        maddr = upd_addr0;
        cause = miss_unpredicted;
      end else if (upd_jump1) begin
        miss1 = 1'b1;
        maddr = upd_addr1;
        cause = miss_unpredicted;
      end
    end
  end

  // Early warning of a slot-0 redirect that squashes slot 1 in this cycle
  assign pred_hazard = miss0;

  always_ff @(posedge clock) begin
    if (!reset) begin
      pred_miss <= 1'b0;
      pred_maddr <= '0;
      pred_cause <= miss_none;
    end else begin
      pred_miss <= miss0 || miss1;
      pred_maddr <= maddr;
      pred_cause <= cause;
    end
  end

endmodule

// ==== btac_top.sv ====
`timescale 1ns/100ps

module btac_top
  import btac_pkg::*;
#(
  parameter int btb_depth = 64,
  parameter int track_depth = 4
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  clear,
  input  logic                  stall,
  input  logic [addr_width-1:0] get_pc0,
  input  logic [addr_width-1:0] get_pc1,
  input  logic [addr_width-1:0] upd_pc0,
  input  logic [addr_width-1:0] upd_npc0,
  input  logic [addr_width-1:0] upd_addr0,
  input  logic                  upd_jump0,
  input  logic                  upd_branch0,
  input  logic                  upd_jal0,
  input  logic [addr_width-1:0] upd_pc1,
  input  logic [addr_width-1:0] upd_npc1,
  input  logic [addr_width-1:0] upd_addr1,
  input  logic                  upd_jump1,
  input  logic                  upd_branch1,
  input  logic                  upd_jal1,
  output logic                  pred_branch,
  output logic [addr_width-1:0] pred_baddr,
  output logic [addr_width-1:0] pred_pc,
  output logic [addr_width-1:0] pred_npc,
  output logic                  pred_miss,
  output logic [addr_width-1:0] pred_maddr,
  output btac_miss_e            pred_cause,
  output logic                  pred_hazard
);

  localparam int idx_width = $clog2(btb_depth);

  logic [idx_width-1:0]   raddr0;
  logic [idx_width-1:0]   raddr1;
  logic [entry_width-1:0] rdata0;
  logic [entry_width-1:0] rdata1;
  logic                   wen;
  logic [idx_width-1:0]   waddr;
  logic [entry_width-1:0] wdata;
  logic                   trk_taken;
  logic [addr_width-1:0]  trk_taddr;
  logic [addr_width-1:0]  trk_tpc;
  logic [addr_width-1:0]  trk_tnpc;
  logic                   trk_retire;

  btb_ram #(
    .btb_depth (btb_depth)
  ) i_btb_ram (
    .clock  (clock),
    .wen    (wen),
    .waddr  (waddr),
    .wdata  (wdata),
    .raddr0 (raddr0),
    .raddr1 (raddr1),
    .rdata0 (rdata0),
    .rdata1 (rdata1)
  );

  btac_predict #(
    .btb_depth (btb_depth)
  ) i_btac_predict (
    .clock       (clock),
    .reset       (reset),
    .clear       (clear),
    .stall       (stall),
    .get_pc0     (get_pc0),
    .get_pc1     (get_pc1),
    .rdata0      (rdata0),
    .rdata1      (rdata1),
    .raddr0      (raddr0),
    .raddr1      (raddr1),
    .pred_branch (pred_branch),
    .pred_baddr  (pred_baddr),
    .pred_pc     (pred_pc),
    .pred_npc    (pred_npc)
  );

  btac_track #(
    .track_depth (track_depth)
  ) i_btac_track (
    .clock       (clock),
    .reset       (reset),
    .clear       (clear),
    .stall       (stall),
    .pred_branch (pred_branch),
    .pred_baddr  (pred_baddr),
    .pred_pc     (pred_pc),
    .pred_npc    (pred_npc),
    .trk_retire  (trk_retire),
    .trk_taken   (trk_taken),
    .trk_taddr   (trk_taddr),
    .trk_tpc     (trk_tpc),
    .trk_tnpc    (trk_tnpc)
  );

  btac_resolve #(
    .btb_depth (btb_depth)
  ) i_btac_resolve (
    .clock       (clock),
    .reset       (reset),
    .clear       (clear),
    .upd_pc0     (upd_pc0),
    .upd_npc0    (upd_npc0),
    .upd_addr0   (upd_addr0),
    .upd_jump0   (upd_jump0),
    .upd_branch0 (upd_branch0),
    .upd_jal0    (upd_jal0),
    .upd_pc1     (upd_pc1),
    .upd_npc1    (upd_npc1),
    .upd_addr1   (upd_addr1),
    .upd_jump1   (upd_jump1),
    .upd_branch1 (upd_branch1),
    .upd_jal1    (upd_jal1),
    .trk_taken   (trk_taken),
    .trk_taddr   (trk_taddr),
    .trk_tpc     (trk_tpc),
    .trk_tnpc    (trk_tnpc),
    .wen         (wen),
    .waddr       (waddr),
    .wdata       (wdata),
    .trk_retire  (trk_retire),
    .pred_miss   (pred_miss),
    .pred_maddr  (pred_maddr),
    .pred_cause  (pred_cause),
    .pred_hazard (pred_hazard)
  );

endmodule

// ==== btac_track.sv ====
`timescale 1ns/100ps

module btac_track
  import btac_pkg::*;
#(
  parameter int track_depth = 4
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  clear,
  input  logic                  stall,
  input  logic                  pred_branch,
  input  logic [addr_width-1:0] pred_baddr,
  input  logic [addr_width-1:0] pred_pc,
  input  logic [addr_width-1:0] pred_npc,
  input  logic                  trk_retire,
  output logic                  trk_taken,
  output logic [addr_width-1:0] trk_taddr,
  output logic [addr_width-1:0] trk_tpc,
  output logic [addr_width-1:0] trk_tnpc
);

  logic [track_depth-1:0] valid_q;
  logic [addr_width-1:0]  taddr_q [track_depth];
  logic [addr_width-1:0]  tpc_q [track_depth];
  logic [addr_width-1:0]  tnpc_q [track_depth];
  logic [track_depth-1:0] oldest;
  logic [track_depth-1:0] valid_kept;

  // One-hot pick of the highest valid slot
  always_comb begin
    oldest = '0;
    for (int i = track_depth - 1; i >= 0; i--) begin
      if (valid_q[i] && oldest == '0) begin
        oldest[i] = 1'b1;
      end
    end
  end

  always_comb begin
    trk_taken = |valid_q;
    trk_taddr = '0;
    trk_tpc = '0;
    trk_tnpc = '0;
    for (int i = 0; i < track_depth; i++) begin
      if (oldest[i]) begin
        trk_taddr = taddr_q[i];
        trk_tpc = tpc_q[i];
        trk_tnpc = tnpc_q[i];
      end
    end
  end

  assign valid_kept = trk_retire ? (valid_q & ~oldest) : valid_q;

  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      valid_q <= '0;
    end else if (stall) begin
      valid_q <= valid_kept;
    end else begin
      // The slot shifted past the end is dropped
      valid_q[0] <= pred_branch;
      for (int i = 1; i < track_depth; i++) begin
        valid_q[i] <= valid_kept[i-1];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      taddr_q[0] <= pred_baddr;
      tpc_q[0] <= pred_pc;
      tnpc_q[0] <= pred_npc;
      for (int i = 1; i < track_depth; i++) begin
        taddr_q[i] <= taddr_q[i-1];
        tpc_q[i] <= tpc_q[i-1];
        tnpc_q[i] <= tnpc_q[i-1];
      end
    end
  end

endmodule

// ==== btb_ram.sv ====
`timescale 1ns/100ps

module btb_ram
  import btac_pkg::*;
#(
  parameter int btb_depth = 64
) (
  input  logic                           clock,
  input  logic                           wen,
  input  logic [$clog2(btb_depth)-1:0]   waddr,
  input  logic [entry_width-1:0]         wdata,
  input  logic [$clog2(btb_depth)-1:0]   raddr0,
  input  logic [$clog2(btb_depth)-1:0]   raddr1,
  output logic [entry_width-1:0]         rdata0,
  output logic [entry_width-1:0]         rdata1
);

  localparam int idx_width = $clog2(btb_depth);

  // Empty entries read as zero and never hit
  logic [entry_width-1:0] mem [0:btb_depth-1] = '{default: '0};

  logic [idx_width-1:0] raddr0_q = '0;
  logic [idx_width-1:0] raddr1_q = '0;

  always_ff @(posedge clock) begin
    raddr0_q <= raddr0;
    raddr1_q <= raddr1;
    if (wen) begin
      mem[waddr] <= wdata;
    end
  end

  assign rdata0 = mem[raddr0_q];
  assign rdata1 = mem[raddr1_q];

endmodule

// ==== tb_btac.sv ====
`timescale 1ns/100ps

module tb_btac
  import btac_pkg::*;
();

  localparam real period = 4.0;
  localparam int reset_cycles = 8;
  localparam int max_vectors = 256;
  localparam int num_fields = 23;
  localparam int btb_entries = 64;

  logic                  clock;
  logic                  reset;
  logic                  clear;
  logic                  stall;
  logic [addr_width-1:0] get_pc0;
  logic [addr_width-1:0] get_pc1;
  logic [addr_width-1:0] upd_pc0;
  logic [addr_width-1:0] upd_npc0;
  logic [addr_width-1:0] upd_addr0;
  logic                  upd_jump0;
  logic                  upd_branch0;
  logic                  upd_jal0;
  logic [addr_width-1:0] upd_pc1;
  logic [addr_width-1:0] upd_npc1;
  logic [addr_width-1:0] upd_addr1;
  logic                  upd_jump1;
  logic                  upd_branch1;
  logic                  upd_jal1;
  logic                  pred_branch;
  logic [addr_width-1:0] pred_baddr;
  logic [addr_width-1:0] pred_pc;
  logic [addr_width-1:0] pred_npc;
  logic                  pred_miss;
  logic [addr_width-1:0] pred_maddr;
  btac_miss_e            pred_cause;
  logic                  pred_hazard;

  // Fields 0..15 are inputs, 16 the check flag, 17..22 expected outputs
  logic [31:0] vec [max_vectors][num_fields];
  string       vec_name [max_vectors];
  int          num_vectors = 0;
  bit          loaded = 1'b0;
  bit          load_ok = 1'b0;
  int          tests = 0;
  int          checks = 0;
  int          errors = 0;
  int          test_checks = 0;
  int          test_errors = 0;

  // Reference BTB contents and the PCs held for the next lookup
  logic [addr_width-1:0] ref_taddr [btb_entries] = '{default: '0};
  logic [addr_width-1:0] ref_pc [btb_entries] = '{default: '0};
  logic [addr_width-1:0] ref_npc [btb_entries] = '{default: '0};
  logic [addr_width-1:0] look_pc0 = '0;
  logic [addr_width-1:0] look_pc1 = '0;

  btac_top i_dut (.*);

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  function automatic int btb_index(input logic [addr_width-1:0] pc);
    return int'((pc >> 2) % btb_entries);
  endfunction

  function automatic bit btb_hit(input logic [addr_width-1:0] pc);
    int idx;
    idx = btb_index(pc);
    return (ref_taddr[idx] != '0 || ref_pc[idx] != '0 || ref_npc[idx] != '0)
           && ref_pc[idx] == pc;
  endfunction

  task automatic load_vectors();
    int          fd;
    int          count;
    int          line_no;
    string       line;
    string       name;
    logic [31:0] f [num_fields];
    line_no = 0;
    fd = $fopen("btac_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden file btac_golden.txt");
    end else begin
      load_ok = 1'b1;
      while (!$feof(fd)) begin
        line = "";
        count = $fgets(line, fd);
        line_no++;
        // Skip comments and blank lines
        if (line.len() > 1 && line.getc(0) != "#") begin
          count = $sscanf(
            line,
            "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
            f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20],
            f[21], f[22]);
          if (count != num_fields + 1) begin
            $display("Golden file line %0d is short, it has %0d of %0d fields",
                     line_no, count, num_fields + 1);
            load_ok = 1'b0;
          end else if (num_vectors == max_vectors) begin
            $display("Golden file has more than %0d vectors", max_vectors);
            load_ok = 1'b0;
          end else begin
            vec_name[num_vectors] = name;
            for (int k = 0; k < num_fields; k++) begin
              vec[num_vectors][k] = f[k];
            end
            num_vectors++;
          end
        end
      end
      $fclose(fd);
      if (num_vectors == 0) begin
        $display("Golden file holds no vectors");
        load_ok = 1'b0;
      end
    end
  endtask

  task automatic apply_vector(input int i);
    clear = vec[i][0][0];
    stall = vec[i][1][0];
    get_pc0 = vec[i][2];
    get_pc1 = vec[i][3];
    upd_pc0 = vec[i][4];
    upd_npc0 = vec[i][5];
    upd_addr0 = vec[i][6];
    upd_jump0 = vec[i][7][0];
    upd_branch0 = vec[i][8][0];
    upd_jal0 = vec[i][9][0];
    upd_pc1 = vec[i][10];
    upd_npc1 = vec[i][11];
    upd_addr1 = vec[i][12];
    upd_jump1 = vec[i][13][0];
    upd_branch1 = vec[i][14][0];
    upd_jal1 = vec[i][15][0];
  endtask

  task automatic record_vector(input int i);
    int idx;
    if (!vec[i][0][0]) begin
      // Slot 0 takes the write when both slots jump
      if (vec[i][7][0] && (vec[i][8][0] || vec[i][9][0])) begin
        idx = btb_index(vec[i][4]);
        ref_taddr[idx] = vec[i][6];
        ref_pc[idx] = vec[i][4];
        ref_npc[idx] = vec[i][5];
      end else if (vec[i][13][0] && (vec[i][14][0] || vec[i][15][0])) begin
        idx = btb_index(vec[i][10]);
        ref_taddr[idx] = vec[i][12];
        ref_pc[idx] = vec[i][10];
        ref_npc[idx] = vec[i][11];
      end
      look_pc0 = vec[i][2];
      look_pc1 = vec[i][3];
    end
  endtask

  task automatic check_value(input string test, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    test_checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("ERROR %s %s: expected %h, actual %h", test, field, expected, actual);
    end
  endtask

  task automatic check_outputs(input int i);
    logic [addr_width-1:0] hit_pc;
    logic [addr_width-1:0] exp_pc;
    logic [addr_width-1:0] exp_npc;
    hit_pc = btb_hit(look_pc0) ? look_pc0 : look_pc1;
    exp_pc = '0;
    exp_npc = '0;
    // PC and next PC come from the entry that hit
    if (vec[i][17][0]) begin
      exp_pc = hit_pc;
      exp_npc = ref_npc[btb_index(hit_pc)];
    end
    check_value(vec_name[i], "pred_branch", vec[i][17], 32'(pred_branch));
    check_value(vec_name[i], "pred_baddr", vec[i][18], pred_baddr);
    check_value(vec_name[i], "pred_pc", exp_pc, pred_pc);
    check_value(vec_name[i], "pred_npc", exp_npc, pred_npc);
    check_value(vec_name[i], "pred_miss", vec[i][19], 32'(pred_miss));
    check_value(vec_name[i], "pred_maddr", vec[i][20], pred_maddr);
    check_value(vec_name[i], "pred_cause", vec[i][21], 32'(pred_cause));
    check_value(vec_name[i], "pred_hazard", vec[i][22], 32'(pred_hazard));
  endtask

  task automatic finish_test(input string test);
    tests++;
    if (test_errors == 0) begin
      $display("Test %s: %0d checks, no errors", test, test_checks);
    end else begin
      $display("Test %s: %0d checks, %0d errors", test, test_checks, test_errors);
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  initial begin
    reset = 1'b0;
    clear = 1'b0;
    stall = 1'b0;
    get_pc0 = '0;
    get_pc1 = '0;
    upd_pc0 = '0;
    upd_npc0 = '0;
    upd_addr0 = '0;
    upd_jump0 = 1'b0;
    upd_branch0 = 1'b0;
    upd_jal0 = 1'b0;
    upd_pc1 = '0;
    upd_npc1 = '0;
    upd_addr1 = '0;
    upd_jump1 = 1'b0;
    upd_branch1 = 1'b0;
    upd_jal1 = 1'b0;
    load_vectors();
    loaded = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    if (load_ok) begin
      for (int i = 0; i < num_vectors; i++) begin
        @(negedge clock);
        apply_vector(i);
        // Sample just before the rising edge
        #(period / 2 - 0.5);
        if (vec[i][16][0]) begin
          check_outputs(i);
        end
        record_vector(i);
        if (i == num_vectors - 1 || vec_name[i + 1] != vec_name[i]) begin
          finish_test(vec_name[i]);
        end
      end
    end
    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (load_ok && errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog sized from the vector count
  initial begin
    wait (loaded);
    #((num_vectors + reset_cycles) * 2 * period + 20 * period);
    $display("Timeout, the vectors did not finish in time");
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
btac_pkg.sv
btb_ram.sv
btac_predict.sv
btac_track.sv
btac_resolve.sv
btac_top.sv
tb_btac.sv
